/* src/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// operand and result width
`define EXEC_DATA_W 32

// general register file address width
`define EXEC_REG_ADDR_W 5

// shift amount taken from the low bits of operand a
`define EXEC_SHAMT_W 5

// opcode width
`define EXEC_OP_W 8

`endif

/* src/exec_pkg.sv */
`include "exec_settings.svh"

package exec_pkg;

	typedef logic [`EXEC_DATA_W-1:0] data_t;
	// hi in the upper word, lo in the lower word
	typedef logic [2*`EXEC_DATA_W-1:0] hilo_t;
	typedef logic [`EXEC_REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [`EXEC_OP_W-1:0] {
		ALU_NOP   = 8'b0000_0000,
		ALU_AND   = 8'b0010_0100,
		ALU_OR    = 8'b0010_0101,
		ALU_XOR   = 8'b0010_0110,
		ALU_NOR   = 8'b0010_0111,
		ALU_SLL   = 8'b0111_1100,
		ALU_SRL   = 8'b0000_0010,
		ALU_SRA   = 8'b0000_0011,
		ALU_MFHI  = 8'b0001_0000,
		ALU_MTHI  = 8'b0001_0001,
		ALU_MFLO  = 8'b0001_0010,
		ALU_MTLO  = 8'b0001_0011,
		ALU_SLT   = 8'b0010_1010,
		ALU_SLTU  = 8'b0010_1011,
		ALU_ADD   = 8'b0010_0000,
		ALU_ADDU  = 8'b0010_0001,
		ALU_SUB   = 8'b0010_0010,
		ALU_SUBU  = 8'b0010_0011,
		ALU_MULT  = 8'b0001_1000,
		ALU_MULTU = 8'b0001_1001,
		ALU_MUL   = 8'b1010_1001,
		ALU_CLZ   = 8'b1011_0000,
		ALU_CLO   = 8'b1011_0001,
		ALU_MADD  = 8'b1010_0110,
		ALU_MADDU = 8'b1010_1000,
		ALU_MSUB  = 8'b1010_1010,
		ALU_MSUBU = 8'b1010_1011
	} aluop_e;

	typedef enum logic [2:0] {
		RES_NONE  = 3'b000,
		RES_LOGIC = 3'b001,
		RES_SHIFT = 3'b010,
		RES_MOVE  = 3'b011,
		RES_ARITH = 3'b100
	} res_class_e;

	// class of the general register result, none when only hi/lo changes
	function automatic res_class_e op_class(input aluop_e op);
		case (op)
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: return RES_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA: return RES_SHIFT;
			ALU_MFHI, ALU_MFLO: return RES_MOVE;
			ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
			ALU_CLZ, ALU_CLO, ALU_MUL: return RES_ARITH;
			default: return RES_NONE;
		endcase
	endfunction

endpackage

/* src/bitwise_shift_unit.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module bitwise_shift_unit
	import exec_pkg::*;
(
	input aluop_e op_i,
	input data_t a_i,
	input data_t b_i,
	output data_t logic_o,
	output data_t shift_o
);

	logic [`EXEC_SHAMT_W-1:0] shamt;

	// shift amount sits in the low bits of a
	assign shamt = a_i[`EXEC_SHAMT_W-1:0];

	always_comb begin
		case (op_i)
			ALU_AND: logic_o = a_i & b_i;
			ALU_OR: logic_o = a_i | b_i;
			ALU_XOR: logic_o = a_i ^ b_i;
			ALU_NOR: logic_o = ~(a_i | b_i);
			default: logic_o = '0;
		endcase
	end

	always_comb begin
		case (op_i)
			ALU_SLL: shift_o = b_i << shamt;
			ALU_SRL: shift_o = b_i >> shamt;
			// sign bit of b fills from the top
			ALU_SRA: shift_o = data_t'($signed(b_i) >>> shamt);
			default: shift_o = '0;
		endcase
	end

endmodule

/* src/arith_unit.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module arith_unit
	import exec_pkg::*;
(
	input aluop_e op_i,
	input data_t a_i,
	input data_t b_i,
	output data_t arith_o,
	output logic overflow_o
);

	localparam int MSB = `EXEC_DATA_W - 1;

	data_t sum;
	data_t diff;
	data_t mul_lo;
	logic add_ovf;
	logic sub_ovf;
	logic [MSB+1:0] sum_x;
	logic [MSB+1:0] diff_x;

	// number of zero bits above the highest set bit
	function automatic data_t lead_zeros(input data_t v);
		data_t n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = MSB; i >= 0; i--) begin
			if (v[i]) begin
				found = 1'b1;
			end else if (!found) begin
				n = n + 1'b1;
			end
		end
		return n;
	endfunction

	assign sum = a_i + b_i;
	assign diff = a_i - b_i;
	// only the low word survives
	assign mul_lo = a_i * b_i;

	// same-sign inputs giving a result of the other sign
	assign add_ovf = (a_i[MSB] == b_i[MSB]) && (sum[MSB] != a_i[MSB]);
	// for a - b the inputs must differ in sign
	assign sub_ovf = (a_i[MSB] != b_i[MSB]) && (diff[MSB] != a_i[MSB]);

	assign overflow_o = ((op_i == ALU_ADD) && add_ovf) || ((op_i == ALU_SUB) && sub_ovf);

	// one extra sign bit keeps the true signed result
	assign sum_x = {a_i[MSB], a_i} + {b_i[MSB], b_i};
	assign diff_x = {a_i[MSB], a_i} - {b_i[MSB], b_i};

	always_comb begin
		case (op_i)
			ALU_ADD, ALU_ADDU: arith_o = sum;
			ALU_SUB, ALU_SUBU: arith_o = diff;
			ALU_SLT: arith_o = data_t'($signed(a_i) < $signed(b_i));
			ALU_SLTU: arith_o = data_t'(a_i < b_i);
			ALU_CLZ: arith_o = lead_zeros(a_i);
			// leading ones are the leading zeros of the complement
			ALU_CLO: arith_o = lead_zeros(~a_i);
			ALU_MUL: arith_o = mul_lo;
			default: arith_o = '0;
		endcase
	end

	// overflow only for signed add and sub, when the top two bits disagree
	always_comb begin
		assert #0 (overflow_o == (((op_i == ALU_ADD) && (sum_x[MSB+1] != sum_x[MSB]))
			|| ((op_i == ALU_SUB) && (diff_x[MSB+1] != diff_x[MSB]))))
			else $error("overflow flag disagrees with the widened result");
	end

endmodule

/* src/mul_acc_unit.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module mul_acc_unit
	import exec_pkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic valid_i,
	input aluop_e op_i,
	input data_t a_i,
	input data_t b_i,
	input hilo_t hilo_i,
	output logic ready_o,
	output logic accept_o,
	output logic mul_we_o,
	output hilo_t mul_hilo_o
);

	logic signed [2*`EXEC_DATA_W-1:0] prod_s;
	hilo_t prod_u;
	hilo_t prod;
	logic is_signed;
	logic is_acc;
	logic is_mul64;

	// second cycle of an accumulate
	logic busy_q;
	hilo_t prod_q;
	logic acc_sub_q;
	hilo_t acc_hilo;

	assign is_signed = op_i inside {ALU_MULT, ALU_MADD, ALU_MSUB};
	assign is_acc = op_i inside {ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU};
	assign is_mul64 = op_i inside {ALU_MULT, ALU_MULTU};

	// full 64 bit products, operands extended before the multiply
	assign prod_s = $signed(a_i) * $signed(b_i);
	assign prod_u = a_i * b_i;
	assign prod = is_signed ? hilo_t'(prod_s) : prod_u;

	assign ready_o = !busy_q;
	assign accept_o = valid_i && ready_o;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			busy_q <= 1'b0;
		end else begin
			busy_q <= accept_o && is_acc;
		end
	end

	always_ff @(posedge clk) begin
		if (accept_o && is_acc) begin
			prod_q <= prod;
			acc_sub_q <= op_i inside {ALU_MSUB, ALU_MSUBU};
		end
	end

	// wraps modulo 2^64
	assign acc_hilo = acc_sub_q ? hilo_i - prod_q : hilo_i + prod_q;

	assign mul_we_o = busy_q || (accept_o && is_mul64);
	assign mul_hilo_o = busy_q ? acc_hilo : prod;

	// hi/lo must not move under a pending accumulate
	assert property (@(posedge clk) disable iff (reset_i)
		accept_o && is_acc |=> $stable(hilo_i))
		else $error("hi/lo changed while an accumulate was pending");

	// upstream holds its request through the stall
	assert property (@(posedge clk) disable iff (reset_i)
		!ready_o && valid_i |=> valid_i && $stable(op_i) && $stable(a_i) && $stable(b_i))
		else $error("issue inputs changed during the stall");

endmodule

/* src/hilo_regfile.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module hilo_regfile
	import exec_pkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic accept_i,
	input aluop_e op_i,
	input data_t a_i,
	input logic mul_we_i,
	input hilo_t mul_hilo_i,
	output hilo_t hilo_o
);

	localparam int W = `EXEC_DATA_W;

	data_t hi_q;
	data_t lo_q;
	logic mthi;
	logic mtlo;

	assign mthi = accept_i && (op_i == ALU_MTHI);
	assign mtlo = accept_i && (op_i == ALU_MTLO);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (mul_we_i) begin
			hi_q <= mul_hilo_i[2*W-1:W];
			lo_q <= mul_hilo_i[W-1:0];
		end else if (mthi) begin
			hi_q <= a_i;
		end else if (mtlo) begin
			lo_q <= a_i;
		end
	end

	assign hilo_o = {hi_q, lo_q};

	// multiplier writes and moves are never issued together
	assert property (@(posedge clk) disable iff (reset_i)
		!(mul_we_i && (mthi || mtlo)))
		else $error("multiplier and move write hi/lo in one cycle");

endmodule

/* src/result_stage.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module result_stage
	import exec_pkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic accept_i,
	input aluop_e op_i,
	input reg_addr_t wd_i,
	input logic wreg_i,
	input data_t logic_i,
	input data_t shift_i,
	input data_t arith_i,
	input logic overflow_i,
	input hilo_t hilo_i,
	output logic wb_valid_o,
	output logic wb_we_o,
	output reg_addr_t wb_addr_o,
	output data_t wb_data_o
);

	localparam int W = `EXEC_DATA_W;

	res_class_e cls;
	data_t move_res;
	data_t result;

	assign cls = op_class(op_i);

	always_comb begin
		case (op_i)
			ALU_MFHI: move_res = hilo_i[2*W-1:W];
			ALU_MFLO: move_res = hilo_i[W-1:0];
			default: move_res = '0;
		endcase
	end

	always_comb begin
		case (cls)
			RES_LOGIC: result = logic_i;
			RES_SHIFT: result = shift_i;
			RES_MOVE: result = move_res;
			RES_ARITH: result = arith_i;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_valid_o <= 1'b0;
			wb_we_o <= 1'b0;
		end else begin
			wb_valid_o <= accept_i;
			// overflowing add/sub still completes, just without the write
			wb_we_o <= accept_i && wreg_i && !overflow_i && (cls != RES_NONE);
		end
	end

	always_ff @(posedge clk) begin
		if (accept_i) begin
			wb_addr_o <= wd_i;
			wb_data_o <= result;
		end
	end

endmodule

/* src/exec_top.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module exec_top
	import exec_pkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic valid_i,
	input aluop_e op_i,
	input data_t a_i,
	input data_t b_i,
	input reg_addr_t wd_i,
	input logic wreg_i,
	output logic ready_o,
	output logic wb_valid_o,
	output logic wb_we_o,
	output reg_addr_t wb_addr_o,
	output data_t wb_data_o
);

	data_t logic_res;
	data_t shift_res;
	data_t arith_res;
	logic overflow;
	logic accept;
	logic mul_we;
	hilo_t mul_hilo;
	hilo_t hilo;

	bitwise_shift_unit u_bitwise_shift_unit (
		.op_i(op_i),
		.a_i(a_i),
		.b_i(b_i),
		.logic_o(logic_res),
		.shift_o(shift_res)
	);

	arith_unit u_arith_unit (
		.op_i(op_i),
		.a_i(a_i),
		.b_i(b_i),
		.arith_o(arith_res),
		.overflow_o(overflow)
	);

	// owns the issue handshake
	mul_acc_unit u_mul_acc_unit (
		.clk(clk),
		.reset_i(reset_i),
		.valid_i(valid_i),
		.op_i(op_i),
		.a_i(a_i),
		.b_i(b_i),
		.hilo_i(hilo),
		.ready_o(ready_o),
		.accept_o(accept),
		.mul_we_o(mul_we),
		.mul_hilo_o(mul_hilo)
	);

	hilo_regfile u_hilo_regfile (
		.clk(clk),
		.reset_i(reset_i),
		.accept_i(accept),
		.op_i(op_i),
		.a_i(a_i),
		.mul_we_i(mul_we),
		.mul_hilo_i(mul_hilo),
		.hilo_o(hilo)
	);

	result_stage u_result_stage (
		.clk(clk),
		.reset_i(reset_i),
		.accept_i(accept),
		.op_i(op_i),
		.wd_i(wd_i),
		.wreg_i(wreg_i),
		.logic_i(logic_res),
		.shift_i(shift_res),
		.arith_i(arith_res),
		.overflow_i(overflow),
		.hilo_i(hilo),
		.wb_valid_o(wb_valid_o),
		.wb_we_o(wb_we_o),
		.wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o)
	);

endmodule

/* tb/exec_tb.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module exec_tb
	import exec_pkg::*;
();

	localparam int W = `EXEC_DATA_W;
	localparam int NUM_RANDOM = 340;
	// ~400 ops at up to two cycles each, plus reset
	localparam int TIMEOUT_CYCLES = 1000;

	logic clk;
	logic reset_i;
	logic valid_i;
	aluop_e op_i;
	data_t a_i;
	data_t b_i;
	reg_addr_t wd_i;
	logic wreg_i;
	logic ready_o;
	logic wb_valid_o;
	logic wb_we_o;
	reg_addr_t wb_addr_o;
	data_t wb_data_o;

	// reference model state
	hilo_t m_hilo;
	hilo_t m_pend;
	logic m_sub;
	logic m_busy;
	logic exp_valid;
	logic exp_we;
	logic exp_gpr;
	reg_addr_t exp_addr;
	data_t exp_data;

	logic [31:0] rng_state;
	int issued = 0;
	int wb_seen = 0;
	int cycles = 0;
	aluop_e op_table[27];

	exec_top u_exec_top (
		.clk(clk),
		.reset_i(reset_i),
		.valid_i(valid_i),
		.op_i(op_i),
		.a_i(a_i),
		.b_i(b_i),
		.wd_i(wd_i),
		.wreg_i(wreg_i),
		.ready_o(ready_o),
		.wb_valid_o(wb_valid_o),
		.wb_we_o(wb_we_o),
		.wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o)
	);

	always #4 clk = ~clk;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [2*W-1:0] dut_val,
			input logic [2*W-1:0] exp_val);
		stop_with_failure($sformatf("MISMATCH at %0t: %s dut=%0h expected=%0h",
			$time, name, dut_val, exp_val));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic next_random(output data_t v);
		rng_state = xorshift32(rng_state);
		v = rng_state;
	endtask

	// corner values half of the time
	task automatic pick_operand(output data_t v);
		data_t r;
		next_random(r);
		case (r[2:0])
			3'd0: v = '0;
			3'd1: v = '1;
			3'd2: v = 32'h8000_0000;
			3'd3: v = 32'h7fff_ffff;
			default: next_random(v);
		endcase
	endtask

	function automatic hilo_t product64(input aluop_e op, input data_t a, input data_t b);
		longint sa;
		longint sb;
		hilo_t ua;
		hilo_t ub;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ua = {{W{1'b0}}, a};
		ub = {{W{1'b0}}, b};
		if (op inside {ALU_MULT, ALU_MADD, ALU_MSUB}) begin
			return hilo_t'(sa * sb);
		end
		return ua * ub;
	endfunction

	// true result must survive truncation to a signed word
	function automatic logic signed_overflow(input aluop_e op, input data_t a, input data_t b);
		longint r;
		data_t t;
		if (op == ALU_ADD) begin
			r = longint'($signed(a)) + longint'($signed(b));
		end else if (op == ALU_SUB) begin
			r = longint'($signed(a)) - longint'($signed(b));
		end else begin
			return 1'b0;
		end
		t = r[W-1:0];
		return r != longint'($signed(t));
	endfunction

	function automatic data_t leading_count(input data_t v, input logic bit_val);
		int i;
		data_t n;
		n = '0;
		i = W - 1;
		while (i >= 0 && v[i] == bit_val) begin
			n = n + 1;
			i = i - 1;
		end
		return n;
	endfunction

	function automatic logic writes_register(input aluop_e op);
		return !(op inside {ALU_NOP, ALU_MULT, ALU_MULTU, ALU_MADD, ALU_MADDU,
			ALU_MSUB, ALU_MSUBU, ALU_MTHI, ALU_MTLO});
	endfunction

	function automatic data_t expected_result(input aluop_e op, input data_t a,
			input data_t b, input hilo_t hl);
		logic [2*W-1:0] wide;
		hilo_t p;
		int sh;
		sh = a[`EXEC_SHAMT_W-1:0];
		// sign copies above b, shifted down
		wide = {{W{b[W-1]}}, b} >> sh;
		p = product64(ALU_MULT, a, b);
		case (op)
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			ALU_NOR: return ~(a | b);
			ALU_SLL: return b << sh;
			ALU_SRL: return b >> sh;
			ALU_SRA: return wide[W-1:0];
			ALU_ADD, ALU_ADDU: return a + b;
			ALU_SUB, ALU_SUBU: return a - b;
			ALU_SLT: return ($signed(a) < $signed(b)) ? 1 : 0;
			ALU_SLTU: return (a < b) ? 1 : 0;
			ALU_CLZ: return leading_count(a, 1'b0);
			ALU_CLO: return leading_count(a, 1'b1);
			ALU_MUL: return p[W-1:0];
			ALU_MFHI: return hl[2*W-1:W];
			ALU_MFLO: return hl[W-1:0];
			default: return '0;
		endcase
	endfunction

	always @(posedge clk) begin : ref_model
		logic acc;
		hilo_t prod;
		acc = valid_i && !m_busy;
		prod = product64(op_i, a_i, b_i);
		if (reset_i) begin
			m_hilo <= '0;
			m_busy <= 1'b0;
			exp_valid <= 1'b0;
			exp_we <= 1'b0;
		end else begin
			exp_valid <= acc;
			exp_we <= acc && wreg_i && writes_register(op_i) &&
				!signed_overflow(op_i, a_i, b_i);
			m_busy <= acc && (op_i inside {ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU});
			if (acc) begin
				exp_gpr <= writes_register(op_i);
				exp_addr <= wd_i;
				exp_data <= expected_result(op_i, a_i, b_i, m_hilo);
			end
			// accumulate lands one cycle after issue
			if (m_busy) begin
				m_hilo <= m_sub ? m_hilo - m_pend : m_hilo + m_pend;
			end else if (acc) begin
				case (op_i)
					ALU_MULT, ALU_MULTU: m_hilo <= prod;
					ALU_MTHI: m_hilo[2*W-1:W] <= a_i;
					ALU_MTLO: m_hilo[W-1:0] <= a_i;
					ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU: begin
						m_pend <= prod;
						m_sub <= op_i inside {ALU_MSUB, ALU_MSUBU};
					end
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset_i) ready_o == !m_busy)
		else report_mismatch("ready_o", $sampled(ready_o), !$sampled(m_busy));

	assert property (@(posedge clk) disable iff (reset_i) wb_valid_o == exp_valid)
		else report_mismatch("wb_valid_o", $sampled(wb_valid_o), $sampled(exp_valid));

	assert property (@(posedge clk) disable iff (reset_i) wb_we_o == exp_we)
		else report_mismatch("wb_we_o", $sampled(wb_we_o), $sampled(exp_we));

	assert property (@(posedge clk) disable iff (reset_i) exp_valid |-> wb_addr_o == exp_addr)
		else report_mismatch("wb_addr_o", $sampled(wb_addr_o), $sampled(exp_addr));

	assert property (@(posedge clk) disable iff (reset_i)
		exp_valid && exp_gpr |-> wb_data_o == exp_data)
		else report_mismatch("wb_data_o", $sampled(wb_data_o), $sampled(exp_data));

	always @(negedge clk) begin
		if (!reset_i && wb_valid_o) begin
			wb_seen++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			stop_with_failure("timeout: the run did not finish within the cycle limit");
		end
	end

	// called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic issue_op(input aluop_e op, input data_t a, input data_t b,
			input reg_addr_t wd, input logic wreg);
		valid_i = 1'b1;
		op_i = op;
		a_i = a;
		b_i = b;
		wd_i = wd;
		wreg_i = wreg;
		while (!ready_o) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		valid_i = 1'b0;
		issued++;
	endtask

	task automatic idle_cycle();
		valid_i = 1'b0;
		@(posedge clk);
		#1;
	endtask

	initial begin
		data_t r;
		data_t a;
		data_t b;
		clk = 1'b0;
		reset_i = 1'b1;
		valid_i = 1'b0;
		op_i = ALU_NOP;
		a_i = '0;
		b_i = '0;
		wd_i = '0;
		wreg_i = 1'b0;
		rng_state = 32'd20;
		op_table = '{ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
			ALU_MFHI, ALU_MTHI, ALU_MFLO, ALU_MTLO, ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU,
			ALU_SUB, ALU_SUBU, ALU_MULT, ALU_MULTU, ALU_MUL, ALU_CLZ, ALU_CLO, ALU_MADD,
			ALU_MADDU, ALU_MSUB, ALU_MSUBU};
		repeat (5) @(posedge clk);
		#1;
		reset_i = 1'b0;

		// hi/lo reads zero after reset
		issue_op(ALU_MFHI, 0, 0, 5'd1, 1'b1);
		issue_op(ALU_MFLO, 0, 0, 5'd2, 1'b1);
		issue_op(ALU_AND, 32'hffff_ffff, 32'h5a5a_a5a5, 5'd3, 1'b1);
		issue_op(ALU_XOR, 32'hffff_ffff, 32'h0f0f_0f0f, 5'd4, 1'b0);
		issue_op(ALU_NOR, 32'h0, 32'h0, 5'd5, 1'b1);
		issue_op(ALU_SLL, 32'd4, 32'h8000_0001, 5'd6, 1'b1);
		issue_op(ALU_SRL, 32'd31, 32'h8000_0000, 5'd7, 1'b1);
		issue_op(ALU_SRA, 32'd8, 32'h8765_4321, 5'd8, 1'b1);
		// overflowing add and sub complete without a write
		issue_op(ALU_ADD, 32'h7fff_ffff, 32'd1, 5'd9, 1'b1);
		issue_op(ALU_SUB, 32'h8000_0000, 32'd1, 5'd10, 1'b1);
		issue_op(ALU_ADD, 32'hffff_ffff, 32'hffff_ffff, 5'd11, 1'b1);
		issue_op(ALU_SUBU, 32'h0, 32'd1, 5'd12, 1'b1);
		issue_op(ALU_SLT, 32'hffff_ffff, 32'd1, 5'd13, 1'b1);
		issue_op(ALU_SLTU, 32'hffff_ffff, 32'd1, 5'd14, 1'b1);
		issue_op(ALU_CLZ, 32'h0, 32'h0, 5'd15, 1'b1);
		issue_op(ALU_CLO, 32'hffff_ffff, 32'h0, 5'd16, 1'b1);
		issue_op(ALU_MUL, 32'hffff_fffd, 32'd7, 5'd17, 1'b1);
		// full products then readback
		issue_op(ALU_MULT, 32'hffff_fffd, 32'd7, 5'd0, 1'b0);
		issue_op(ALU_MFHI, 0, 0, 5'd18, 1'b1);
		issue_op(ALU_MFLO, 0, 0, 5'd19, 1'b1);
		issue_op(ALU_MULTU, 32'hffff_ffff, 32'hffff_ffff, 5'd0, 1'b0);
		issue_op(ALU_MFHI, 0, 0, 5'd20, 1'b1);
		issue_op(ALU_MFLO, 0, 0, 5'd21, 1'b1);
		// accumulates, back to back
		issue_op(ALU_MADD, 32'h8000_0000, 32'h8000_0000, 5'd0, 1'b0);
		issue_op(ALU_MSUBU, 32'hffff_ffff, 32'd2, 5'd0, 1'b0);
		issue_op(ALU_MSUB, 32'd3, 32'hffff_fffb, 5'd0, 1'b0);
		issue_op(ALU_MFHI, 0, 0, 5'd22, 1'b1);
		issue_op(ALU_MFLO, 0, 0, 5'd23, 1'b1);
		// each move touches one half only
		issue_op(ALU_MTHI, 32'hdead_beef, 0, 5'd0, 1'b0);
		issue_op(ALU_MFHI, 0, 0, 5'd24, 1'b1);
		issue_op(ALU_MFLO, 0, 0, 5'd25, 1'b1);
		issue_op(ALU_MTLO, 32'h0, 0, 5'd0, 1'b0);
		issue_op(ALU_MFHI, 0, 0, 5'd26, 1'b1);
		issue_op(ALU_MFLO, 0, 0, 5'd27, 1'b1);

		for (int n = 0; n < NUM_RANDOM; n++) begin
			next_random(r);
			if (r[26:24] == 3'd0) begin
				idle_cycle();
			end
			pick_operand(a);
			pick_operand(b);
			issue_op(op_table[r[15:0] % 27], a, b, r[20:16], r[21] | r[22]);
		end

		repeat (3) @(posedge clk);
		if (wb_seen != issued) begin
			stop_with_failure($sformatf("%0d operations issued but %0d writebacks seen",
				issued, wb_seen));
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

/* project.f */
+incdir+src
src/exec_pkg.sv
src/bitwise_shift_unit.sv
src/arith_unit.sv
src/mul_acc_unit.sv
src/hilo_regfile.sv
src/result_stage.sv
src/exec_top.sv
tb/exec_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - include_dirs:
      - src
    files:
      - src/exec_pkg.sv
      - src/bitwise_shift_unit.sv
      - src/arith_unit.sv
      - src/mul_acc_unit.sv
      - src/hilo_regfile.sv
      - src/result_stage.sv
      - src/exec_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/exec_tb.sv
